// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Memory map
	localparam logic [ADDR_W-1:0] GFX_BASE   = 32'h0200_0000;
	localparam int                GFX_SPAN_W = 8;
	localparam logic [ADDR_W-1:0] BOOT_BASE  = 32'h0201_0000;

	localparam logic [DATA_W-1:0] GFX_ID = 32'h4758_0100; // Graphics block identifier

	typedef struct packed {
		logic              sel;
		logic              enable;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
	} apb_req_t;

	typedef struct packed {
		logic              ready;
		logic [DATA_W-1:0] rdata;
		logic              slverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {OWN_NONE, OWN_HOST, OWN_GFX} owner_e;

	typedef enum logic [1:0] {REG_ID, REG_CTRL, REG_FB_BASE, REG_SCRATCH} gfx_reg_e;

	// Byte lane merge for strobed writes
	function automatic logic [DATA_W-1:0] strb_merge(input logic [DATA_W-1:0] old_word,
	                                                 input logic [DATA_W-1:0] new_word,
	                                                 input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] result;
		result = old_word;
		for (int i = 0; i < STRB_W; i++) begin
			if (strb[i])
				result[8*i +: 8] = new_word[8*i +: 8];
		end
		return result;
	endfunction

endpackage

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  logic              hdmi_pixClk,
	input  logic              rst_n,
	input  soc_pkg::apb_req_t host_req,
	input  soc_pkg::apb_req_t gfx_req,
	input  soc_pkg::apb_rsp_t bus_rsp,
	output soc_pkg::apb_rsp_t host_rsp,
	output soc_pkg::apb_rsp_t gfx_rsp,
	output soc_pkg::apb_req_t bus_req
);
	import soc_pkg::*;

	owner_e owner_q;
	owner_e owner_cur;
	owner_e grant;
	logic   host_won_q; // Host was served last
	logic   contend;
	logic   done;

	assign contend = host_req.sel & gfx_req.sel;

	always_comb begin
		grant = OWN_NONE;
		if (contend)
			grant = host_won_q ? OWN_GFX : OWN_HOST; // One not served last wins
		else if (host_req.sel)
			grant = OWN_HOST;
		else if (gfx_req.sel)
			grant = OWN_GFX;
	end

	// Decide in the idle cycle so the setup phase is not delayed
	assign owner_cur = (owner_q == OWN_NONE) ? grant : owner_q;

	always_comb begin
		bus_req  = '0;
		host_rsp = '0;
		gfx_rsp  = '0;
		case (owner_cur)
			OWN_HOST: begin
				bus_req  = host_req;
				host_rsp = bus_rsp;
			end
			OWN_GFX: begin
				bus_req  = gfx_req;
				gfx_rsp  = bus_rsp;
			end
			default: ;
		endcase
		// A waiting requester already holds enable high
		if (owner_q == OWN_NONE)
			bus_req.enable = 1'b0;
	end

	assign done = bus_req.sel & bus_req.enable & bus_rsp.ready;

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			owner_q    <= OWN_NONE;
			host_won_q <= 1'b0;
		end else begin
			owner_q <= done ? OWN_NONE : owner_cur;
			if (done)
				host_won_q <= (owner_q == OWN_HOST);
		end
	end

	// Access phase on the shared bus runs to ready without a change of owner
	a_owner_held: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		(bus_req.sel && bus_req.enable && !bus_rsp.ready) |=> $stable(bus_req));

endmodule

`default_nettype wire

// ==== addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_decoder #(
	parameter int BOOT_WORDS = 256
) (
	input  soc_pkg::apb_req_t bus_req,
	output soc_pkg::apb_rsp_t bus_rsp,
	output soc_pkg::apb_req_t boot_req,
	input  soc_pkg::apb_rsp_t boot_rsp,
	output soc_pkg::apb_req_t gfx_reg_req,
	input  soc_pkg::apb_rsp_t gfx_reg_rsp
);
	import soc_pkg::*;

	localparam int BOOT_SPAN_W = $clog2(BOOT_WORDS) + 2; // Byte address bits

	logic boot_hit;
	logic gfx_hit;

	assign boot_hit = bus_req.addr[ADDR_W-1:BOOT_SPAN_W] == BOOT_BASE[ADDR_W-1:BOOT_SPAN_W];
	assign gfx_hit  = bus_req.addr[ADDR_W-1:GFX_SPAN_W] == GFX_BASE[ADDR_W-1:GFX_SPAN_W];

	always_comb begin
		// Same request to both, only the hit target sees sel
		boot_req        = bus_req;
		boot_req.sel    = bus_req.sel & boot_hit;
		gfx_reg_req     = bus_req;
		gfx_reg_req.sel = bus_req.sel & gfx_hit;

		if (boot_hit) begin
			bus_rsp = boot_rsp;
		end else if (gfx_hit) begin
			bus_rsp = gfx_reg_rsp;
		end else begin
			// Unmapped completes at once with an error
			bus_rsp.ready  = bus_req.sel & bus_req.enable;
			bus_rsp.rdata  = '0;
			bus_rsp.slverr = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== boot_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_ram #(
	parameter int BOOT_WORDS = 256
) (
	input  logic              hdmi_pixClk,
	input  logic              rst_n,
	input  soc_pkg::apb_req_t boot_req,
	output soc_pkg::apb_rsp_t boot_rsp
);
	import soc_pkg::*;

	localparam int IDX_W = $clog2(BOOT_WORDS);

	logic [DATA_W-1:0] mem [BOOT_WORDS];
	logic [IDX_W-1:0]  idx;
	logic              access;
	logic              wait_q; // Set after the first access cycle

	assign idx    = boot_req.addr[IDX_W+1:2]; // Word index
	assign access = boot_req.sel & boot_req.enable;

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n)
			wait_q <= 1'b0;
		else
			wait_q <= access & ~wait_q;
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (access && wait_q && boot_req.write)
			mem[idx] <= strb_merge(mem[idx], boot_req.wdata, boot_req.strb);
	end

	always_comb begin
		boot_rsp.ready  = access & wait_q;
		boot_rsp.rdata  = mem[idx];
		boot_rsp.slverr = 1'b0;
	end

	// Requester must hold everything through the wait state
	a_req_stable: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		(access && !boot_rsp.ready) |=> $stable(boot_req));

endmodule

`default_nettype wire

// ==== gfx_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module gfx_regs (
	input  logic              hdmi_pixClk,
	input  logic              rst_n,
	input  soc_pkg::apb_req_t gfx_reg_req,
	output soc_pkg::apb_rsp_t gfx_reg_rsp
);
	import soc_pkg::*;

	gfx_reg_e          reg_sel;
	logic [DATA_W-1:0] ctrl_q;
	logic [DATA_W-1:0] fb_base_q;
	logic [DATA_W-1:0] scratch_q;
	logic              access;
	logic              wr;

	assign reg_sel = gfx_reg_e'(gfx_reg_req.addr[3:2]);
	assign access  = gfx_reg_req.sel & gfx_reg_req.enable;
	assign wr      = access & gfx_reg_req.write;

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q    <= '0;
			fb_base_q <= '0;
			scratch_q <= '0;
		end else if (wr) begin
			case (reg_sel)
				REG_CTRL:
					ctrl_q <= strb_merge(ctrl_q, gfx_reg_req.wdata, gfx_reg_req.strb);
				REG_FB_BASE:
					fb_base_q <= strb_merge(fb_base_q, gfx_reg_req.wdata, gfx_reg_req.strb);
				REG_SCRATCH:
					scratch_q <= strb_merge(scratch_q, gfx_reg_req.wdata, gfx_reg_req.strb);
				default: ; // ID is read only
			endcase
		end
	end

	always_comb begin
		gfx_reg_rsp.ready  = access; // No wait states
		gfx_reg_rsp.slverr = wr & (reg_sel == REG_ID);
		case (reg_sel)
			REG_ID:      gfx_reg_rsp.rdata = GFX_ID;
			REG_CTRL:    gfx_reg_rsp.rdata = ctrl_q;
			REG_FB_BASE: gfx_reg_rsp.rdata = fb_base_q;
			default:     gfx_reg_rsp.rdata = scratch_q;
		endcase
	end

endmodule

`default_nettype wire

// ==== soc_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_fabric #(
	parameter int BOOT_WORDS = 256
) (
	input  logic              hdmi_pixClk,
	input  logic              rst_n,
	input  soc_pkg::apb_req_t host_req,
	output soc_pkg::apb_rsp_t host_rsp,
	input  soc_pkg::apb_req_t gfx_req,
	output soc_pkg::apb_rsp_t gfx_rsp
);
	import soc_pkg::*;

	apb_req_t bus_req;
	apb_rsp_t bus_rsp;
	apb_req_t boot_req;
	apb_rsp_t boot_rsp;
	apb_req_t gfx_reg_req;
	apb_rsp_t gfx_reg_rsp;

	// Host and graphics requesters share one bus
	bus_arbiter arbiter (
		.hdmi_pixClk (hdmi_pixClk),
		.rst_n       (rst_n),
		.host_req    (host_req),
		.gfx_req     (gfx_req),
		.bus_rsp     (bus_rsp),
		.host_rsp    (host_rsp),
		.gfx_rsp     (gfx_rsp),
		.bus_req     (bus_req)
	);

	addr_decoder #(
		.BOOT_WORDS (BOOT_WORDS)
	) decoder (
		.bus_req     (bus_req),
		.bus_rsp     (bus_rsp),
		.boot_req    (boot_req),
		.boot_rsp    (boot_rsp),
		.gfx_reg_req (gfx_reg_req),
		.gfx_reg_rsp (gfx_reg_rsp)
	);

	boot_ram #(
		.BOOT_WORDS (BOOT_WORDS)
	) bootloader (
		.hdmi_pixClk (hdmi_pixClk),
		.rst_n       (rst_n),
		.boot_req    (boot_req),
		.boot_rsp    (boot_rsp)
	);

	gfx_regs graphics (
		.hdmi_pixClk (hdmi_pixClk),
		.rst_n       (rst_n),
		.gfx_reg_req (gfx_reg_req),
		.gfx_reg_rsp (gfx_reg_rsp)
	);

endmodule

`default_nettype wire

// ==== tb_soc_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_fabric;
	import soc_pkg::*;

	localparam int BOOT_WORDS     = 256;
	localparam int TIMEOUT_CYCLES = 20;

	logic     hdmi_pixClk;
	logic     rst_n;
	apb_req_t host_req;
	apb_rsp_t host_rsp;
	apb_req_t gfx_req;
	apb_rsp_t gfx_rsp;

	int fail_count;
	int pass_tests;
	int fail_tests;
	int contentions; // Contended transfers so far

	soc_fabric #(
		.BOOT_WORDS (BOOT_WORDS)
	) DUT (
		.hdmi_pixClk (hdmi_pixClk),
		.rst_n       (rst_n),
		.host_req    (host_req),
		.host_rsp    (host_rsp),
		.gfx_req     (gfx_req),
		.gfx_rsp     (gfx_rsp)
	);

	always #10 hdmi_pixClk = ~hdmi_pixClk;

	task automatic drive_port(input logic is_gfx, input apb_req_t req);
		if (is_gfx)
			gfx_req = req;
		else
			host_req = req;
	endtask

	// Setup cycle, then access phase held until ready
	task automatic apb_transfer(input logic is_gfx, input logic wr,
			input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
			input logic [STRB_W-1:0] strb, output logic [DATA_W-1:0] rdata,
			output logic err, output time done_t, output logic timed_out);
		apb_req_t req;
		apb_rsp_t rsp;
		int       cycles;
		logic     got;
		req       = '0;
		req.sel   = 1'b1;
		req.write = wr;
		req.addr  = addr;
		req.wdata = wdata;
		req.strb  = strb;
		rdata     = 'x;
		err       = 1'bx;
		done_t    = 0;
		cycles    = 0;
		got       = 1'b0;
		@(posedge hdmi_pixClk);
		#1 drive_port(is_gfx, req);
		@(posedge hdmi_pixClk);
		req.enable = 1'b1;
		#1 drive_port(is_gfx, req);
		while (!got && cycles < TIMEOUT_CYCLES) begin
			@(negedge hdmi_pixClk); // Response settled mid-cycle
			rsp = is_gfx ? gfx_rsp : host_rsp;
			if (rsp.ready) begin
				got    = 1'b1;
				rdata  = rsp.rdata;
				err    = rsp.slverr;
				done_t = $time;
			end else begin
				cycles++;
			end
		end
		timed_out = !got;
		if (!got)
			$display("Timeout: %0s port saw no ready within %0d cycles of its access phase",
				is_gfx ? "gfx" : "host", TIMEOUT_CYCLES);
		@(posedge hdmi_pixClk);
		#1 drive_port(is_gfx, '0);
	endtask

	task automatic check_response(input string who, input logic wr,
			input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] rdata, input logic err,
			input logic [DATA_W-1:0] exp_rdata, input logic exp_err);
		assert (err === exp_err) else begin
			$display("[FAIL] %0t: %0s at %h slverr %b, expected %b",
				$time, who, addr, err, exp_err);
			fail_count++;
		end
		// Write responses carry no data
		if (!wr) begin
			assert (rdata === exp_rdata) else begin
				$display("[FAIL] %0t: %0s at %h rdata %h, expected %h",
					$time, who, addr, rdata, exp_rdata);
				fail_count++;
			end
		end
	endtask

	initial begin
		int                fd;
		int                code;
		int                ch;
		int                test_no;
		int                fails_before;
		logic              reading;
		string             port_s;
		string             dir_s;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
		logic [DATA_W-1:0] exp_rdata;
		logic              exp_err;
		logic              wr;
		logic [DATA_W-1:0] host_rdata;
		logic [DATA_W-1:0] gfx_rdata;
		logic              host_err;
		logic              gfx_err;
		time               host_t;
		time               gfx_t;
		logic              host_to;
		logic              gfx_to;
		logic              host_last;

		hdmi_pixClk = 1'b0;
		rst_n       = 1'b0;
		host_req    = '0;
		gfx_req     = '0;
		fail_count  = 0;
		pass_tests  = 0;
		fail_tests  = 0;
		contentions = 0;
		test_no     = 0;
		reading     = 1'b1;
		host_last   = 1'b0; // Host wins first after reset
		repeat (10) @(posedge hdmi_pixClk);
		#1 rst_n = 1'b1;

		fd = $fopen("soc_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open soc_vectors.txt");
			fail_count++;
			reading = 1'b0;
		end
		while (reading) begin
			code = $fscanf(fd, "%s", port_s);
			if (code != 1) begin
				reading = 1'b0;
			end else if (port_s == "#") begin
				ch = 0;
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end else begin
				code = $fscanf(fd, "%s %h %h %h %h %h", dir_s, addr, wdata, strb,
					exp_rdata, exp_err);
				if (code != 6) begin
					$display("Vector line after test %0d is malformed", test_no);
					fail_count++;
					reading = 1'b0;
				end else begin
					test_no++;
					fails_before = fail_count;
					wr = (dir_s == "w");
					gfx_to = 1'b0;
					if (port_s == "both") begin
						fork
							apb_transfer(1'b0, wr, addr, wdata, strb, host_rdata, host_err,
								host_t, host_to);
							apb_transfer(1'b1, wr, addr, wdata, strb, gfx_rdata, gfx_err,
								gfx_t, gfx_to);
						join
						if (!host_to && !gfx_to) begin
							check_response("host", wr, addr, host_rdata, host_err,
								exp_rdata, exp_err);
							check_response("gfx", wr, addr, gfx_rdata, gfx_err,
								exp_rdata, exp_err);
							// Port not served last goes first
							assert (host_last ? gfx_t < host_t : host_t < gfx_t) else begin
								$display("[FAIL] %0t: contention %0d served %0s first, expected %0s",
									$time, contentions, host_t < gfx_t ? "host" : "gfx",
									host_last ? "gfx" : "host");
								fail_count++;
							end
						end
						// Loser finishes last, so the last served port stays the same
						contentions++;
					end else begin
						apb_transfer(port_s == "gfx", wr, addr, wdata, strb, host_rdata,
							host_err, host_t, host_to);
						host_last = (port_s == "host");
						if (!host_to)
							check_response(port_s, wr, addr, host_rdata, host_err,
								exp_rdata, exp_err);
					end
					if (host_to || gfx_to) begin
						fail_count++;
						reading = 1'b0;
					end
					if (fail_count == fails_before)
						pass_tests++;
					else
						fail_tests++;
					$display("Test %0d (%0s %0s %h): %0s", test_no, port_s, dir_s, addr,
						fail_count == fails_before ? "passed" : "FAILED");
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (test_no == 0) begin
			$display("No test vectors were run");
			fail_count++;
		end

		$display("Tests: %0d passed, %0d failed, %0d check errors",
			pass_tests, fail_tests, fail_count);
		if (fail_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== soc_vectors.txt ====
# port dir addr wdata strb exp_rdata exp_err
# port is host, gfx or both; dir is w or r; rdata is only checked on reads
host w 02010010 11223344 f 00000000 0
host w 02010010 aabbccdd 5 00000000 0
host r 02010010 00000000 0 11bb33dd 0
gfx w 02000004 00000003 f 00000000 0
gfx w 02000008 80000000 f 00000000 0
gfx w 0200000c 12345678 f 00000000 0
gfx w 02000004 0000ff00 2 00000000 0
host r 02000004 00000000 0 0000ff03 0
host r 02000008 00000000 0 80000000 0
gfx r 0200000c 00000000 0 12345678 0
host r 02000000 00000000 0 47580100 0
# error responses
gfx w 02000000 deadbeef f 00000000 1
host r 02000000 00000000 0 47580100 0
host r 10000000 00000000 0 00000000 1
gfx w 10000000 01234567 f 00000000 1
# contention, then shared data between the ports
both r 02000008 00000000 0 80000000 0
host w 02010020 cafef00d f 00000000 0
gfx r 02010020 00000000 0 cafef00d 0
gfx w 0200000c 5a5aa5a5 f 00000000 0
host r 0200000c 00000000 0 5a5aa5a5 0
both r 02010010 00000000 0 11bb33dd 0
both r 02000000 00000000 0 47580100 0

// ==== tb.f ====
soc_pkg.sv
bus_arbiter.sv
addr_decoder.sv
boot_ram.sv
gfx_regs.sv
soc_fabric.sv
tb_soc_fabric.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc_fabric
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := All tests passed!
FAIL_MSG  := Test failures found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
